// File: src/dcache_pkg.sv
package dcache_pkg;

    // geometry
    localparam int word_bits   = 32;
    localparam int word_bytes  = word_bits / 8;
    localparam int way_bits    = 2;
    localparam int index_bits  = 2;
    localparam int offset_bits = 2;
    localparam int align_bits  = 2;
    localparam int tag_bits    = word_bits - index_bits - offset_bits - align_bits;

    localparam int num_ways    = 1 << way_bits;
    localparam int num_sets    = 1 << index_bits;
    localparam int num_words   = 1 << offset_bits;
    localparam int num_entries = num_ways * num_sets * num_words;

    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [way_bits-1:0]    way_t;
    typedef logic [word_bits-1:0]   word_t;
    typedef logic [word_bytes-1:0]  strobe_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [align_bits-1:0] zeros;
    } addr_t;

    // word position inside data_ram
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } pos_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } record_t;

    typedef record_t [num_ways-1:0] meta_t;
    typedef tag_t    [num_ways-1:0] tags_t;
    typedef logic    [num_ways-2:0] select_t;

    typedef enum logic [1:0] {
        cop_none,
        cop_index_inv,
        cop_index_wb_inv,
        cop_hit_wb_inv
    } cop_e;

    typedef enum logic [2:0] {
        idle,
        read,
        write,
        fill,
        flush
    } miss_state_e;

    // processor side
    typedef struct packed {
        logic    req;
        logic    is_write;
        strobe_t strobe;
        addr_t   addr;
        word_t   data;
        cop_e    cop;
    } dbus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    // memory side
    typedef struct packed {
        logic  valid;
        logic  is_write;
        addr_t addr;
        word_t wdata;
    } cbus_req_t;

    typedef struct packed {
        logic  okay;
        logic  last;
        word_t rdata;
    } cbus_resp_t;

endpackage

// File: src/set_ram.sv
module set_ram #(
    parameter int width = 8
) (
    input  logic               clk,
    input  logic               resetn,
    input  dcache_pkg::index_t addr,
    input  logic [width-1:0]   wdata,
    output logic [width-1:0]   rdata
);
    import dcache_pkg::*;

    logic [width-1:0] mem [num_sets];

    // combinational read
    // the new value lands on the next edge
    assign rdata = mem[addr];

    always_ff @(posedge clk) begin
        if (resetn) begin
            // all records start out invalid
            for (int i = 0; i < num_sets; i++) begin
                mem[i] <= '0;
            end
        end else begin
            mem[addr] <= wdata;
        end
    end

endmodule

// File: src/plru.sv
module plru (
    input  dcache_pkg::select_t select,
    input  dcache_pkg::way_t    hit_way,
    output dcache_pkg::way_t    victim,
    output dcache_pkg::select_t new_select
);
    import dcache_pkg::*;

    // tree layout
    // select[0] is the root and points at ways 0/1 when low
    // select[1] picks inside ways 0/1 and select[2] inside ways 2/3
    logic root;
    logic left;
    logic right;

    assign root  = select[0];
    assign left  = select[1];
    assign right = select[2];

    // follow the bits down to the least recently used way
    always_comb begin
        if (!root) begin
            victim = {1'b0, left};
        end else begin
            victim = {1'b1, right};
        end
    end

    // bits on the path to the hit way now point to the other side
    always_comb begin
        new_select = select;
        if (!hit_way[1]) begin
            new_select[0] = 1'b1;
            new_select[1] = ~hit_way[0];
        end else begin
            new_select[0] = 1'b0;
            new_select[2] = ~hit_way[0];
        end
    end

endmodule

// File: src/data_ram.sv
module data_ram (
    input  logic                clk,

    // port 1 serves hits
    input  logic                en_1,
    input  dcache_pkg::strobe_t strobe_1,
    input  dcache_pkg::pos_t    pos_1,
    input  dcache_pkg::word_t   wdata_1,
    output dcache_pkg::word_t   rdata_1,

    // port 2 serves fills and victim reads
    input  dcache_pkg::strobe_t strobe_2,
    input  dcache_pkg::pos_t    pos_2,
    input  dcache_pkg::word_t   wdata_2,
    output dcache_pkg::word_t   rdata_2
);
    import dcache_pkg::*;

    word_t mem [num_entries];

    // read-first on both ports
    always_ff @(posedge clk) begin
        if (en_1) begin
            rdata_1 <= mem[pos_1];
            for (int b = 0; b < word_bytes; b++) begin
                if (strobe_1[b]) begin
                    mem[pos_1][8*b +: 8] <= wdata_1[8*b +: 8];
                end
            end
        end

        rdata_2 <= mem[pos_2];
        for (int b = 0; b < word_bytes; b++) begin
            if (strobe_2[b]) begin
                mem[pos_2][8*b +: 8] <= wdata_2[8*b +: 8];
            end
        end
    end

endmodule

// File: src/dcache.sv
module dcache (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::dbus_req_t  dbus_req,
    output dcache_pkg::dbus_resp_t dbus_resp,
    output dcache_pkg::cbus_req_t  cbus_req,
    input  dcache_pkg::cbus_resp_t cbus_resp
);
    import dcache_pkg::*;

    typedef word_t [num_words-1:0] buffer_t;

    addr_t req_addr;
    assign req_addr = dbus_req.addr;

    // per-set storage read at the request index
    meta_t   meta, new_meta;
    tags_t   tags, new_tags;
    select_t sel,  new_sel;

    set_ram #(.width($bits(meta_t))) meta_ram_inst (
        .clk(clk), .resetn(resetn), .addr(req_addr.index),
        .wdata(new_meta), .rdata(meta)
    );
    set_ram #(.width($bits(tags_t))) tags_ram_inst (
        .clk(clk), .resetn(resetn), .addr(req_addr.index),
        .wdata(new_tags), .rdata(tags)
    );
    set_ram #(.width($bits(select_t))) select_ram_inst (
        .clk(clk), .resetn(resetn), .addr(req_addr.index),
        .wdata(new_sel), .rdata(sel)
    );

    // tag lookup over all ways
    logic [num_ways-1:0] hit_bits;
    logic                req_hit;
    way_t                req_way;

    always_comb begin
        req_way = '0;
        for (int i = 0; i < num_ways; i++) begin
            hit_bits[i] = meta[i].valid && tags[i] == req_addr.tag;
            if (hit_bits[i]) begin
                req_way = way_t'(i);
            end
        end
    end
    assign req_hit = |hit_bits;

    way_t    victim;
    select_t plru_sel;

    plru plru_inst (
        .select(sel), .hit_way(req_way),
        .victim(victim), .new_select(plru_sel)
    );

    // miss/flush machine state
    miss_state_e         state;
    addr_t               miss_addr;
    pos_t                miss_pos;
    logic [num_words-1:0] miss_ready;
    record_t             vrecord;
    tag_t                vtag;
    logic                vwrten;
    offset_t             voffset;
    buffer_t             vbuf;
    logic                hit_data_ok;

    logic  miss_busy;
    logic  miss_avail;
    logic  miss_is_dirty;
    logic  req_in_miss;
    logic  req_miss_ready;
    word_t rdata_1;
    word_t rdata_2;

    assign miss_busy     = state != idle;
    assign miss_is_dirty = vrecord.valid && vrecord.dirty;
    // a new miss may start on the last beat of a write-back
    assign miss_avail    = state == idle ||
                           ((state == write || state == flush) && cbus_resp.last);

    // only ready words of a line being filled may be touched
    assign req_in_miss    = miss_busy && req_addr.tag == miss_addr.tag &&
                            req_addr.index == miss_addr.index;
    assign req_miss_ready = !req_in_miss || miss_ready[req_addr.offset];

    // cache operations
    logic  cop_req;
    logic  cop_index;
    logic  cop_wb;
    logic  cop_target;
    logic  cop_update;
    logic  cop_flush;
    way_t  cop_way;
    addr_t flush_addr;

    assign cop_req    = dbus_req.req && dbus_req.cop != cop_none;
    assign cop_index  = dbus_req.cop == cop_index_inv || dbus_req.cop == cop_index_wb_inv;
    assign cop_wb     = dbus_req.cop == cop_index_wb_inv || dbus_req.cop == cop_hit_wb_inv;
    assign cop_way    = cop_index ? way_t'(req_addr.tag) : req_way;
    assign cop_target = cop_index || req_hit;
    assign cop_update = cop_req && !miss_busy;
    assign cop_flush  = cop_update && cop_wb && cop_target &&
                        meta[cop_way].valid && meta[cop_way].dirty;

    assign flush_addr = '{tag: tags[cop_way], index: req_addr.index, offset: '0, zeros: '0};

    logic req_to_hit;
    logic req_to_miss;

    assign req_to_hit  = dbus_req.req && !cop_req && req_hit && req_miss_ready;
    assign req_to_miss = dbus_req.req && !cop_req && !req_hit && miss_avail;

    data_ram data_ram_inst (
        .clk(clk),
        .en_1(req_to_hit),
        .strobe_1(dbus_req.is_write ? dbus_req.strobe : strobe_t'(0)),
        .pos_1('{way: req_way, index: req_addr.index, offset: req_addr.offset}),
        .wdata_1(dbus_req.data),
        .rdata_1(rdata_1),
        .strobe_2(state == read && cbus_resp.okay ? '1 : strobe_t'(0)),
        .pos_2(miss_pos),
        .wdata_2(cbus_resp.rdata),
        .rdata_2(rdata_2)
    );

    // updated per-set values written back every cycle
    assign new_sel = req_to_hit ? plru_sel : sel;

    always_comb begin
        new_meta = meta;
        new_tags = tags;
        if (cop_update) begin
            // every operation invalidates its line
            if (cop_target) begin
                new_meta[cop_way] = '0;
            end
        end else if (req_to_hit) begin
            if (dbus_req.is_write) begin
                new_meta[req_way].dirty = 1'b1;
            end
        end else if (req_to_miss) begin
            new_meta[victim].valid = 1'b1;
            new_meta[victim].dirty = 1'b0;
            new_tags[victim]       = req_addr.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state       <= idle;
            hit_data_ok <= 1'b0;
            vwrten      <= 1'b0;
            miss_ready  <= '0;
        end else begin
            hit_data_ok <= req_to_hit || cop_update;

            unique case (state)
                read: begin
                    // old word shows up on rdata_2 one cycle after the fill write
                    vwrten <= cbus_resp.okay;
                    if (cbus_resp.okay) begin
                        miss_ready[miss_pos.offset] <= 1'b1;
                    end
                    if (cbus_resp.last) begin
                        state <= miss_is_dirty ? write : idle;
                    end
                end
                write, flush: begin
                    vwrten <= 1'b0;
                    if (cbus_resp.last) begin
                        state <= idle;
                    end
                end
                fill: begin
                    vwrten <= 1'b1;
                    if (miss_pos.offset == offset_t'(num_words - 1)) begin
                        state <= flush;
                    end
                end
                default: vwrten <= 1'b0;
            endcase

            if (req_to_miss) begin
                state      <= read;
                miss_ready <= '0;
            end else if (cop_flush) begin
                state      <= fill;
                miss_ready <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        voffset <= miss_pos.offset;
        if (vwrten) begin
            vbuf[voffset] <= rdata_2;
        end

        // bursts always walk offsets 0 to 3
        if ((state inside {read, write, flush} && cbus_resp.okay) || state == fill) begin
            miss_pos.offset <= offset_t'(miss_pos.offset + 1'b1);
        end
        if (state == read && cbus_resp.last) begin
            miss_addr.tag <= vtag;
        end

        if (req_to_miss) begin
            miss_addr <= '{tag: req_addr.tag, index: req_addr.index, offset: '0, zeros: '0};
            miss_pos  <= '{way: victim, index: req_addr.index, offset: '0};
            vrecord   <= meta[victim];
            vtag      <= tags[victim];
        end else if (cop_flush) begin
            miss_addr <= flush_addr;
            miss_pos  <= '{way: cop_way, index: req_addr.index, offset: '0};
        end
    end

    assign dbus_resp.addr_ok = cop_req ? cop_update : (req_hit && req_miss_ready);
    assign dbus_resp.data_ok = hit_data_ok;
    assign dbus_resp.data    = rdata_1;

    assign cbus_req.valid    = state == read || state == write || state == flush;
    assign cbus_req.is_write = state == write || state == flush;
    assign cbus_req.addr     = miss_addr;
    assign cbus_req.wdata    = vbuf[miss_pos.offset];

endmodule

// File: test/mem_model.sv
module mem_model (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::cbus_req_t  cbus_req,
    output dcache_pkg::cbus_resp_t cbus_resp
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    // only written words live here, so it doubles as the write log
    word_t   written [word_t];
    word_t   rng;
    offset_t beat;
    offset_t next_beat;
    logic    go;

    function automatic word_t xorshift(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // untouched words hold their address xor a fixed pattern
    function automatic word_t word_at(word_t a);
        if (written.exists(a)) begin
            return written[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    // msb set when the address has been written back
    function automatic logic [32:0] logged(word_t a);
        if (written.exists(a)) begin
            return {1'b1, written[a]};
        end
        return '0;
    endfunction

    assign next_beat = cbus_resp.okay ? offset_t'(beat + 1'b1) : beat;
    // random stall on about a quarter of the cycles
    assign go = cbus_req.valid && !(cbus_resp.okay && cbus_resp.last) && rng[1:0] != 2'b00;

    always @(posedge clk) begin
        addr_t a;
        if (resetn) begin
            rng       <= 32'h24ac;
            beat      <= '0;
            cbus_resp <= '0;
        end else begin
            rng <= xorshift(rng);
            a = cbus_req.addr;
            if (cbus_resp.okay && cbus_req.is_write) begin
                a.offset = beat;
                written[a] = cbus_req.wdata;
            end
            a.offset = next_beat;
            beat            <= next_beat;
            cbus_resp.okay  <= go;
            cbus_resp.last  <= go && next_beat == offset_t'(num_words - 1);
            cbus_resp.rdata <= word_at(a);
        end
    end

endmodule

// File: test/dcache_tb.sv
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    // longest any single wait may take in cycles
    localparam int max_wait = 300;

    logic       clk;
    logic       resetn;
    dbus_req_t  dbus_req;
    dbus_resp_t dbus_resp;
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;

    int errors;
    int timeouts;
    int commands;

    dcache dcache_inst (
        .clk(clk),
        .resetn(resetn),
        .dbus_req(dbus_req),
        .dbus_resp(dbus_resp),
        .cbus_req(cbus_req),
        .cbus_resp(cbus_resp)
    );

    mem_model mem_model_inst (
        .clk(clk),
        .resetn(resetn),
        .cbus_req(cbus_req),
        .cbus_resp(cbus_resp)
    );

    initial begin
        clk = 1'b0;
    end

    always begin
        #5 clk = ~clk;
    end

    task automatic check(input word_t got, input word_t expected, input string what);
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // one processor request held until accepted
    task automatic run_command(input string op, input word_t addr, input strobe_t strobe,
                               input word_t data, input word_t expected, output logic ok);
        dbus_req_t r;
        int        n;
        r          = '0;
        r.req      = 1'b1;
        r.addr     = addr;
        r.data     = data;
        r.is_write = op == "w";
        r.strobe   = op == "w" ? strobe : strobe_t'(0);
        case (op)
            "i": r.cop = cop_index_inv;
            "b": r.cop = cop_index_wb_inv;
            "h": r.cop = cop_hit_wb_inv;
            default: r.cop = cop_none;
        endcase
        ok = 1'b0;
        @(posedge clk);
        dbus_req <= r;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!dbus_resp.addr_ok && n < max_wait);
        if (!dbus_resp.addr_ok) begin
            $display("timeout: %s request at %h was never accepted", op, addr);
            return;
        end
        @(posedge clk);
        dbus_req.req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!dbus_resp.data_ok && n < max_wait);
        if (!dbus_resp.data_ok) begin
            $display("timeout: no data_ok for %s request at %h", op, addr);
            return;
        end
        check(word_t'(n), 1, $sformatf("data_ok delay for %s at %h", op, addr));
        if (op == "r") begin
            check(dbus_resp.data, expected, $sformatf("read at %h", addr));
        end
        ok = 1'b1;
    endtask

    // wait for the write-back of one word to reach memory
    task automatic check_memory(input word_t addr, input word_t expected, output logic ok);
        logic [32:0] entry;
        int          n;
        n = 0;
        do begin
            @(negedge clk);
            entry = mem_model_inst.logged(addr);
            n++;
        end while (!entry[32] && n < max_wait);
        ok = entry[32];
        if (!ok) begin
            $display("timeout: no write-back reached address %h", addr);
        end else begin
            check(entry[31:0], expected, $sformatf("memory at %h", addr));
        end
    endtask

    initial begin
        int      fd;
        int      count;
        string   line;
        string   op;
        word_t   addr;
        strobe_t strobe;
        word_t   data;
        word_t   expected;
        logic    ok;
        errors   = 0;
        timeouts = 0;
        commands = 0;
        resetn   = 1'b1;
        dbus_req = '0;
        repeat (3) @(posedge clk);
        resetn <= 1'b0;

        fd = $fopen("test/dcache_tests.txt", "r");
        ok = fd != 0;
        if (!ok) begin
            $display("could not open test/dcache_tests.txt");
            errors++;
        end
        while (ok && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            count = $sscanf(line, "%s %h %h %h %h", op, addr, strobe, data, expected);
            if (count != 5) begin
                $display("bad line in test file: %s", line);
                errors++;
                continue;
            end
            commands++;
            if (op == "m") begin
                check_memory(addr, expected, ok);
            end else begin
                run_command(op, addr, strobe, data, expected, ok);
            end
            if (!ok) begin
                timeouts++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("errors: %0d, timeouts: %0d, commands: %0d", errors, timeouts, commands);
        if (errors == 0 && timeouts == 0 && commands > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: dcache.f
src/dcache_pkg.sv
src/set_ram.sv
src/plru.sv
src/data_ram.sv
src/dcache.sv
test/mem_model.sv
test/dcache_tb.sv

// File: Makefile
# Verilator build and run for the dcache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/dcache_tests.txt
# columns: op addr strobe data expected, all hex
# op: r read, w write, i index inv, b index wb inv, h hit wb inv, m memory write log
r 00000014 0 00000000 5a5a0014
r 00000014 0 00000000 5a5a0014
r 00000010 0 00000000 5a5a0010
w 00000018 3 aabbccdd 00000000
r 00000018 0 00000000 5a5accdd
w 0000001c 8 11223344 00000000
r 0000001c 0 00000000 115a001c
w 00000004 f 12345678 00000000
r 00000040 0 00000000 5a5a0040
r 00000080 0 00000000 5a5a0080
r 000000c0 0 00000000 5a5a00c0
r 00000100 0 00000000 5a5a0100
m 00000004 0 00000000 12345678
m 00000000 0 00000000 5a5a0000
m 0000000c 0 00000000 5a5a000c
r 00000004 0 00000000 12345678
r 00000008 0 00000000 5a5a0008
w 00000028 f deadbeef 00000000
h 00000020 0 00000000 00000000
m 00000028 0 00000000 deadbeef
m 00000024 0 00000000 5a5a0024
r 00000028 0 00000000 deadbeef
w 0000003c f 0badf00d 00000000
b 00000030 0 00000000 00000000
m 0000003c 0 00000000 0badf00d
r 0000003c 0 00000000 0badf00d
i 00000010 0 00000000 00000000
r 00000018 0 00000000 5a5a0018
r 0000001c 0 00000000 5a5a001c
r 00000ff4 0 00000000 5a5a0ff4
r 12345670 0 00000000 486e5670
